//--- rename_stage.f
+incdir+source
source/rename_types_pkg.sv
source/stage_pkg.sv
source/rob_alloc.sv
source/spec_rat.sv
source/commit_rat.sv
source/arch_regfile.sv
source/rename_stage.sv
testbench/rename_stage_tb.sv

//--- Bender.yml
package:
  name: rename_stage

sources:
  - include_dirs:
      - source
    files:
      - source/rename_types_pkg.sv
      - source/stage_pkg.sv
      - source/rob_alloc.sv
      - source/spec_rat.sv
      - source/commit_rat.sv
      - source/arch_regfile.sv
      - source/rename_stage.sv

  - target: test
    include_dirs:
      - source
    files:
      - testbench/rename_stage_tb.sv

//--- testbench/rename_stage_tb.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_stage_tb;

    localparam int NUM_GROUPS = 2000;
    localparam int CYCLE_NS   = 100;

    logic                          clk;
    logic                          rst_n_i;
    logic                          flush_i;
    logic                          in_valid_i;
    stage_pkg::decode_pkg_t        in_pkg_i;
    logic                          in_ready_o;
    logic                          out_ready_i;
    logic                          out_valid_o;
    stage_pkg::rename_pkg_t        out_pkg_o;
    logic [1:0]                    retire_i;
    stage_pkg::retire_pkg_t [1:0]  retire_info_i;

    // reference model state
    rename_types_pkg::rat_entry_t  spec_m [`ARF_DEPTH];
    rename_types_pkg::rat_entry_t  commit_m [`ARF_DEPTH];
    rename_types_pkg::reg_data_t   regs_m [`ARF_DEPTH];
    rename_types_pkg::rob_id_t     ptr_m;
    rename_types_pkg::rob_cnt_t    cnt_m;
    logic                          room_m;
    logic                          exp_valid;
    stage_pkg::rename_pkg_t        exp_pkg;
    stage_pkg::retire_pkg_t        writers [$];
    integer                        seed;
    int                            groups;
    int                            cycles;
    int                            err_cnt;

    rename_stage i_dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .in_valid_i    (in_valid_i),
        .in_pkg_i      (in_pkg_i),
        .in_ready_o    (in_ready_o),
        .out_ready_i   (out_ready_i),
        .out_valid_o   (out_valid_o),
        .out_pkg_o     (out_pkg_o),
        .retire_i      (retire_i),
        .retire_info_i (retire_info_i)
    );

    always #(CYCLE_NS / 2) clk = ~clk;

    function automatic int draw(input int n);
        return {$random(seed)} % n;
    endfunction

    task automatic stop_on_error();
        err_cnt++;
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rob(input string name, input rename_types_pkg::rob_id_t got,
                             input rename_types_pkg::rob_id_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_data(input string name, input rename_types_pkg::reg_data_t got,
                              input rename_types_pkg::reg_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_decode(input string name, input stage_pkg::decode_pkg_t got,
                                input stage_pkg::decode_pkg_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_entry_flags(input string name, input logic [3:0] got,
                                     input logic [3:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // decode fields carried through the stage unchanged
    function automatic stage_pkg::decode_pkg_t decode_part(input stage_pkg::rename_pkg_t p);
        stage_pkg::decode_pkg_t d;
        d.pc         = p.pc;
        d.slot_valid = p.slot_valid;
        d.src_id     = p.src_id;
        d.dst_id     = p.dst_id;
        d.w_reg      = p.w_reg;
        d.reg_need   = p.reg_need;
        d.use_imm    = p.use_imm;
        d.imm        = p.imm;
        d.alu        = p.alu;
        d.mdu        = p.mdu;
        d.lsu        = p.lsu;
        return d;
    endfunction

    function automatic logic retire_writes(input int s);
        return retire_i[s] && retire_info_i[s].w_valid && (retire_info_i[s].arf_id != 0);
    endfunction

    // committed entry as seen this cycle, retiring slot 1 on top
    function automatic rename_types_pkg::rat_entry_t commit_view(
            input rename_types_pkg::arf_id_t id);
        rename_types_pkg::rat_entry_t e;
        e = commit_m[id];
        for (int s = 0; s < 2; s++) begin
            if (retire_writes(s) && retire_info_i[s].arf_id == id) begin
                e.check = retire_info_i[s].w_check;
                e.robid = retire_info_i[s].rob_id;
            end
        end
        return e;
    endfunction

    function automatic rename_types_pkg::reg_data_t reg_view(
            input rename_types_pkg::arf_id_t id);
        rename_types_pkg::reg_data_t d;
        d = regs_m[id];
        for (int s = 0; s < 2; s++) begin
            if (retire_writes(s) && retire_info_i[s].arf_id == id) begin
                d = retire_info_i[s].data;
            end
        end
        return d;
    endfunction

    task automatic drive_inputs();
        int n_ret;
        flush_i     = (draw(150) == 0);
        out_ready_i = (draw(8) != 0);
        in_valid_i  = (draw(4) != 0);
        in_pkg_i.pc         = $random(seed);
        in_pkg_i.slot_valid = draw(4);
        in_pkg_i.w_reg      = draw(4);
        in_pkg_i.reg_need   = draw(16);
        in_pkg_i.use_imm    = draw(2);
        in_pkg_i.imm        = $random(seed);
        in_pkg_i.alu        = draw(256);
        in_pkg_i.mdu        = draw(256);
        in_pkg_i.lsu        = draw(256);
        for (int s = 0; s < 2; s++) begin
            in_pkg_i.dst_id[s] = draw(`ARF_DEPTH);
        end
        // slot 1 sources never read the slot 0 destination
        for (int r = 0; r < 4; r++) begin
            in_pkg_i.src_id[r] = draw(`ARF_DEPTH);
            if (r >= 2 && in_pkg_i.src_id[r] == in_pkg_i.dst_id[0]) begin
                in_pkg_i.src_id[r] = in_pkg_i.src_id[r] + 1;
            end
        end
        // alternate phases without and with retirement to reach the stall level
        n_ret    = (flush_i || (cycles / 400) % 2 == 1) ? 0 : draw(3);
        retire_i = '0;
        for (int s = 0; s < 2; s++) begin
            retire_info_i[s].w_valid = draw(2);
            retire_info_i[s].arf_id  = draw(`ARF_DEPTH);
            retire_info_i[s].rob_id  = draw(`ROB_DEPTH);
            retire_info_i[s].w_check = draw(2);
            retire_info_i[s].data    = $random(seed);
            if (s < n_ret && writers.size() > 0) begin
                retire_info_i[s]      = writers.pop_front();
                retire_info_i[s].data = $random(seed);
                retire_i[s]           = 1'b1;
            end
        end
    endtask

    task automatic model_cycle();
        logic                         ready;
        logic                         accept;
        int                           issued;
        stage_pkg::rename_pkg_t       e;
        stage_pkg::retire_pkg_t       w;
        rename_types_pkg::rat_entry_t ne;
        rename_types_pkg::rat_entry_t ce;
        ready  = room_m & ~flush_i & out_ready_i;
        check_bit("in_ready_o", in_ready_o, ready);
        accept = in_valid_i & ready;
        issued = 0;
        e      = exp_pkg;
        if (accept) begin
            e.pc         = in_pkg_i.pc;
            e.slot_valid = in_pkg_i.slot_valid;
            e.src_id     = in_pkg_i.src_id;
            e.dst_id     = in_pkg_i.dst_id;
            e.w_reg      = in_pkg_i.w_reg;
            e.reg_need   = in_pkg_i.reg_need;
            e.use_imm    = in_pkg_i.use_imm;
            e.imm        = in_pkg_i.imm;
            e.alu        = in_pkg_i.alu;
            e.mdu        = in_pkg_i.mdu;
            e.lsu        = in_pkg_i.lsu;
            for (int r = 0; r < 4; r++) begin
                e.src_rob[r]    = spec_m[in_pkg_i.src_id[r]].robid;
                e.src_data[r]   = reg_view(in_pkg_i.src_id[r]);
                e.data_valid[r] = ~in_pkg_i.reg_need[r]
                                | (spec_m[in_pkg_i.src_id[r]] == commit_view(in_pkg_i.src_id[r]));
            end
            for (int s = 0; s < 2; s++) begin
                ce             = commit_view(in_pkg_i.dst_id[s]);
                e.dst_rob[s]   = ptr_m + s;
                e.dst_check[s] = ~ce.check;
            end
            for (int s = 0; s < 2; s++) begin
                if (in_pkg_i.slot_valid[s]) begin
                    issued++;
                    w.w_valid = in_pkg_i.w_reg[s];
                    w.arf_id  = in_pkg_i.dst_id[s];
                    w.rob_id  = e.dst_rob[s];
                    w.w_check = e.dst_check[s];
                    w.data    = '0;
                    writers.push_back(w);
                    if (in_pkg_i.w_reg[s] && in_pkg_i.dst_id[s] != 0) begin
                        ne.check = e.dst_check[s];
                        ne.robid = e.dst_rob[s];
                        spec_m[in_pkg_i.dst_id[s]] = ne;
                    end
                end
            end
            groups++;
        end
        for (int s = 0; s < 2; s++) begin
            if (retire_writes(s)) begin
                commit_m[retire_info_i[s].arf_id].check = retire_info_i[s].w_check;
                commit_m[retire_info_i[s].arf_id].robid = retire_info_i[s].rob_id;
                regs_m[retire_info_i[s].arf_id]         = retire_info_i[s].data;
            end
        end
        room_m = (cnt_m <= `ROB_STALL_LEVEL);
        cnt_m  = cnt_m + issued - retire_i[0] - retire_i[1];
        ptr_m  = ptr_m + issued;
        if (out_ready_i) begin
            exp_valid = accept;
        end
        exp_pkg = e;
        if (flush_i) begin
            for (int i = 0; i < `ARF_DEPTH; i++) begin
                spec_m[i]   = '0;
                commit_m[i] = '0;
            end
            writers.delete();
            room_m    = 1'b1;
            cnt_m     = '0;
            ptr_m     = '0;
            exp_valid = 1'b0;
        end
    endtask

    task automatic check_outputs();
        check_bit("out_valid_o", out_valid_o, exp_valid);
        if (exp_valid) begin
            check_decode("out_pkg_o decode fields", decode_part(out_pkg_o),
                         decode_part(exp_pkg));
            for (int s = 0; s < 2; s++) begin
                check_rob($sformatf("out_pkg_o.dst_rob[%0d]", s),
                          out_pkg_o.dst_rob[s], exp_pkg.dst_rob[s]);
            end
            for (int r = 0; r < 4; r++) begin
                check_rob($sformatf("out_pkg_o.src_rob[%0d]", r),
                          out_pkg_o.src_rob[r], exp_pkg.src_rob[r]);
                check_data($sformatf("out_pkg_o.src_data[%0d]", r),
                           out_pkg_o.src_data[r], exp_pkg.src_data[r]);
            end
            check_entry_flags("out_pkg_o.data_valid", out_pkg_o.data_valid, exp_pkg.data_valid);
            check_entry_flags("out_pkg_o.dst_check", {2'b00, out_pkg_o.dst_check},
                              {2'b00, exp_pkg.dst_check});
        end
    endtask

    initial begin
        #(NUM_GROUPS * 20 * CYCLE_NS);
        $display("watchdog expired before %0d groups were renamed", NUM_GROUPS);
        stop_on_error();
    end

    initial begin
        seed          = 32'he5b4;
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        in_valid_i    = 1'b0;
        in_pkg_i      = '0;
        out_ready_i   = 1'b1;
        retire_i      = '0;
        retire_info_i = '0;
        for (int i = 0; i < `ARF_DEPTH; i++) begin
            spec_m[i]   = '0;
            commit_m[i] = '0;
            regs_m[i]   = '0;
        end
        ptr_m     = '0;
        cnt_m     = '0;
        room_m    = 1'b1;
        exp_valid = 1'b0;
        exp_pkg   = '0;
        groups    = 0;
        cycles    = 0;
        err_cnt   = 0;
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        while (groups < NUM_GROUPS) begin
            drive_inputs();
            #1;
            model_cycle();
            @(negedge clk);
            check_outputs();
            cycles++;
        end
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_on_error();
        end
    end

endmodule

//--- source/rename_stage.sv
`timescale 1ns/1ns

module rename_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          flush_i,
    input  logic                          in_valid_i,
    input  stage_pkg::decode_pkg_t        in_pkg_i,
    output logic                          in_ready_o,
    input  logic                          out_ready_i,
    output logic                          out_valid_o,
    output stage_pkg::rename_pkg_t        out_pkg_o,
    input  logic [1:0]                    retire_i,
    input  stage_pkg::retire_pkg_t [1:0]  retire_info_i
);

    logic                                accept;
    logic                                room;
    logic [1:0]                          issue;
    logic [1:0]                          spec_we;
    logic [1:0]                          commit_we;
    rename_types_pkg::rob_id_t [1:0]     slot_rob;
    rename_types_pkg::rat_entry_t [1:0]  spec_new;
    rename_types_pkg::rat_entry_t [3:0]  spec_src;
    rename_types_pkg::arf_id_t [5:0]     commit_raddr;
    rename_types_pkg::rat_entry_t [5:0]  commit_rd;
    rename_types_pkg::arf_id_t [1:0]     retire_id;
    rename_types_pkg::rat_entry_t [1:0]  commit_new;
    rename_types_pkg::reg_data_t [1:0]   retire_data;
    rename_types_pkg::reg_data_t [3:0]   src_data;
    logic [3:0]                          data_valid;
    stage_pkg::rename_pkg_t              pkg_d;
    stage_pkg::rename_pkg_t              pkg_q;
    logic                                out_valid_q;

    assign in_ready_o = room & ~flush_i & out_ready_i;
    assign accept     = in_valid_i & in_ready_o;
    assign issue      = in_pkg_i.slot_valid & {2{accept}};

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            spec_we[s]   = issue[s] & in_pkg_i.w_reg[s] & (|in_pkg_i.dst_id[s]);
            commit_we[s] = retire_i[s] & retire_info_i[s].w_valid
                         & (|retire_info_i[s].arf_id);
            retire_id[s]   = retire_info_i[s].arf_id;
            retire_data[s] = retire_info_i[s].data;
            commit_new[s].check = retire_info_i[s].w_check;
            commit_new[s].robid = retire_info_i[s].rob_id;
            // flip against the committed entry so a live rename is told apart
            spec_new[s].check = ~commit_rd[4 + s].check;
            spec_new[s].robid = slot_rob[s];
        end
        for (int r = 0; r < 4; r++) begin
            commit_raddr[r] = in_pkg_i.src_id[r];
        end
        commit_raddr[4] = in_pkg_i.dst_id[0];
        commit_raddr[5] = in_pkg_i.dst_id[1];
    end

    rob_alloc i_rob_alloc (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .issue_i    (issue),
        .retire_i   (retire_i),
        .slot_rob_o (slot_rob),
        .room_o     (room)
    );

    spec_rat i_spec_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .raddr_i (in_pkg_i.src_id),
        .rdata_o (spec_src),
        .waddr_i (in_pkg_i.dst_id),
        .we_i    (spec_we),
        .wdata_i (spec_new)
    );

    commit_rat i_commit_rat (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .raddr_i (commit_raddr),
        .rdata_o (commit_rd),
        .waddr_i (retire_id),
        .we_i    (commit_we),
        .wdata_i (commit_new)
    );

    arch_regfile i_arch_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (in_pkg_i.src_id),
        .rdata_o (src_data),
        .waddr_i (retire_id),
        .we_i    (commit_we),
        .wdata_i (retire_data)
    );

    // equal entries mean no writer in flight, so the file value is final
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            data_valid[r] = ~in_pkg_i.reg_need[r] | (spec_src[r] == commit_rd[r]);
        end
    end

    always_comb begin
        pkg_d.pc         = in_pkg_i.pc;
        pkg_d.slot_valid = in_pkg_i.slot_valid;
        pkg_d.src_id     = in_pkg_i.src_id;
        pkg_d.dst_id     = in_pkg_i.dst_id;
        pkg_d.w_reg      = in_pkg_i.w_reg;
        pkg_d.reg_need   = in_pkg_i.reg_need;
        pkg_d.use_imm    = in_pkg_i.use_imm;
        pkg_d.imm        = in_pkg_i.imm;
        pkg_d.alu        = in_pkg_i.alu;
        pkg_d.mdu        = in_pkg_i.mdu;
        pkg_d.lsu        = in_pkg_i.lsu;
        pkg_d.dst_rob    = slot_rob;
        pkg_d.dst_check  = {spec_new[1].check, spec_new[0].check};
        pkg_d.src_data   = src_data;
        pkg_d.data_valid = data_valid;
        for (int r = 0; r < 4; r++) begin
            pkg_d.src_rob[r] = spec_src[r].robid;
        end
    end

    // output holds while dispatch stalls
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            out_valid_q <= 1'b0;
        end else if (out_ready_i) begin
            out_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pkg_q <= pkg_d;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_pkg_o   = pkg_q;

endmodule

//--- source/arch_regfile.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module arch_regfile (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  rename_types_pkg::arf_id_t [3:0]     raddr_i,
    output rename_types_pkg::reg_data_t [3:0]   rdata_o,
    input  rename_types_pkg::arf_id_t [1:0]     waddr_i,
    input  logic [1:0]                          we_i,
    input  rename_types_pkg::reg_data_t [1:0]   wdata_i
);

    localparam int RD_PORTS = 4;
    localparam int WR_PORTS = 2;

    rename_types_pkg::reg_data_t regs_q [`ARF_DEPTH];

    // contents survive a flush, only reset clears them
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int e = 0; e < `ARF_DEPTH; e++) begin
                regs_q[e] <= '0;
            end
        end else begin
            for (int w = 0; w < WR_PORTS; w++) begin
                if (we_i[w]) begin
                    regs_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // bypass of retiring data, slot 1 over slot 0
    always_comb begin
        for (int r = 0; r < RD_PORTS; r++) begin
            rdata_o[r] = regs_q[raddr_i[r]];
            for (int w = 0; w < WR_PORTS; w++) begin
                if (we_i[w] && (waddr_i[w] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[w];
                end
            end
        end
    end

endmodule

//--- source/commit_rat.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module commit_rat (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,
    input  rename_types_pkg::arf_id_t [5:0]      raddr_i,
    output rename_types_pkg::rat_entry_t [5:0]   rdata_o,
    input  rename_types_pkg::arf_id_t [1:0]      waddr_i,
    input  logic [1:0]                           we_i,
    input  rename_types_pkg::rat_entry_t [1:0]   wdata_i
);

    // ports 0..3 serve sources, 4 and 5 serve destinations
    localparam int RD_PORTS = 6;
    localparam int WR_PORTS = 2;

    rename_types_pkg::rat_entry_t rat_q [`ARF_DEPTH];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int e = 0; e < `ARF_DEPTH; e++) begin
                rat_q[e] <= '0;
            end
        end else if (flush_i) begin
            for (int e = 0; e < `ARF_DEPTH; e++) begin
                rat_q[e] <= '0;
            end
        end else begin
            for (int w = 0; w < WR_PORTS; w++) begin
                if (we_i[w]) begin
                    rat_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // same-cycle retire is visible to readers, later slot on top
    always_comb begin
        for (int r = 0; r < RD_PORTS; r++) begin
            rdata_o[r] = rat_q[raddr_i[r]];
            for (int w = 0; w < WR_PORTS; w++) begin
                if (we_i[w] && (waddr_i[w] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[w];
                end
            end
        end
    end

endmodule

//--- source/spec_rat.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module spec_rat (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,
    input  rename_types_pkg::arf_id_t [3:0]      raddr_i,
    output rename_types_pkg::rat_entry_t [3:0]   rdata_o,
    input  rename_types_pkg::arf_id_t [1:0]      waddr_i,
    input  logic [1:0]                           we_i,
    input  rename_types_pkg::rat_entry_t [1:0]   wdata_i
);

    localparam int RD_PORTS = 4;
    localparam int WR_PORTS = 2;

    rename_types_pkg::rat_entry_t rat_q [`ARF_DEPTH];

    // slot 1 is written last so it wins a shared destination
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int e = 0; e < `ARF_DEPTH; e++) begin
                rat_q[e] <= '0;
            end
        end else if (flush_i) begin
            for (int e = 0; e < `ARF_DEPTH; e++) begin
                rat_q[e] <= '0;
            end
        end else begin
            for (int w = 0; w < WR_PORTS; w++) begin
                if (we_i[w]) begin
                    rat_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < RD_PORTS; r++) begin
            rdata_o[r] = rat_q[raddr_i[r]];
        end
    end

endmodule

//--- source/rob_alloc.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module rob_alloc (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               flush_i,
    input  logic [1:0]                         issue_i,
    input  logic [1:0]                         retire_i,
    output rename_types_pkg::rob_id_t [1:0]    slot_rob_o,
    output logic                               room_o
);

    rename_types_pkg::rob_cnt_t cnt_q;
    rename_types_pkg::rob_cnt_t cnt_d;
    rename_types_pkg::rob_id_t  ptr_a_q;
    rename_types_pkg::rob_id_t  ptr_b_q;
    rename_types_pkg::rob_id_t  step;
    logic                       room_q;

    always_comb begin
        step  = rename_types_pkg::rob_id_t'(issue_i[0])
              + rename_types_pkg::rob_id_t'(issue_i[1]);
        cnt_d = cnt_q
              + rename_types_pkg::rob_cnt_t'(issue_i[0])
              + rename_types_pkg::rob_cnt_t'(issue_i[1])
              - rename_types_pkg::rob_cnt_t'(retire_i[0])
              - rename_types_pkg::rob_cnt_t'(retire_i[1]);
    end

    // room looks at the current count, so it trails the count by a cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q   <= '0;
            ptr_a_q <= '0;
            ptr_b_q <= rename_types_pkg::rob_id_t'(1);
            room_q  <= 1'b1;
        end else if (flush_i) begin
            cnt_q   <= '0;
            ptr_a_q <= '0;
            ptr_b_q <= rename_types_pkg::rob_id_t'(1);
            room_q  <= 1'b1;
        end else begin
            cnt_q   <= cnt_d;
            ptr_a_q <= ptr_a_q + step;
            ptr_b_q <= ptr_b_q + step;
            room_q  <= (cnt_q <= `ROB_STALL_LEVEL);
        end
    end

    assign slot_rob_o[0] = ptr_a_q;
    assign slot_rob_o[1] = ptr_b_q;
    assign room_o        = room_q;

endmodule

//--- source/stage_pkg.sv
package stage_pkg;

    // execution unit op code, not decoded here
    typedef logic [7:0] op_type_t;

    // group from decode
    typedef struct packed {
        rename_types_pkg::reg_data_t      pc;
        logic [1:0]                       slot_valid;
        rename_types_pkg::arf_id_t [3:0]  src_id;
        rename_types_pkg::arf_id_t [1:0]  dst_id;
        logic [1:0]                       w_reg;
        logic [3:0]                       reg_need;
        logic                             use_imm;
        rename_types_pkg::reg_data_t      imm;
        op_type_t                         alu;
        op_type_t                         mdu;
        op_type_t                         lsu;
    } decode_pkg_t;

    // group to dispatch
    typedef struct packed {
        rename_types_pkg::reg_data_t      pc;
        logic [1:0]                       slot_valid;
        rename_types_pkg::arf_id_t [3:0]  src_id;
        rename_types_pkg::arf_id_t [1:0]  dst_id;
        logic [1:0]                       w_reg;
        logic [3:0]                       reg_need;
        logic                             use_imm;
        rename_types_pkg::reg_data_t      imm;
        op_type_t                         alu;
        op_type_t                         mdu;
        op_type_t                         lsu;
        rename_types_pkg::rob_id_t [1:0]  dst_rob;
        rename_types_pkg::rob_id_t [3:0]  src_rob;
        logic [1:0]                       dst_check;
        rename_types_pkg::reg_data_t [3:0] src_data;
        logic [3:0]                       data_valid;
    } rename_pkg_t;

    // one retiring instruction
    typedef struct packed {
        logic                        w_valid;
        rename_types_pkg::arf_id_t   arf_id;
        rename_types_pkg::rob_id_t   rob_id;
        logic                        w_check;
        rename_types_pkg::reg_data_t data;
    } retire_pkg_t;

endpackage

//--- source/rename_types_pkg.sv
`include "rename_settings.svh"

package rename_types_pkg;

    // architectural register id
    typedef logic [$clog2(`ARF_DEPTH)-1:0] arf_id_t;

    // reorder buffer slot id
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_id_t;

    // occupancy needs one extra bit to reach the full depth
    typedef logic [$clog2(`ROB_DEPTH):0] rob_cnt_t;

    typedef logic [`DATA_WIDTH-1:0] reg_data_t;

    // alias table entry
    // check flips on every rename so that a live mapping never equals
    // the committed mapping of the same register
    typedef struct packed {
        logic    check;
        rob_id_t robid;
    } rat_entry_t;

endpackage

//--- source/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// architectural register count, register zero included
`define ARF_DEPTH 32

// reorder buffer slots, pointers wrap at this depth
`define ROB_DEPTH 64

// highest occupancy at which new groups are still taken
// leaves room for one more two-wide group plus pipeline slack
`define ROB_STALL_LEVEL 60

// register and immediate data width
`define DATA_WIDTH 32

`endif
